/* design/access_path.sv */
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module access_path
  import dcache_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   cpu_req,
  input  logic                   cpu_wr,
  input  logic [1:0]             cpu_size,
  input  logic [1:0]             cpu_lane,
  input  logic [`DC_ADDR_W-1:0]  cpu_addr,
  input  logic [`DC_WORD_W-1:0]  cpu_wdata,
  input  dc_word_u               old_word,
  input  logic                   hit,
  output logic                   req_valid,
  output logic                   req_wr,
  output logic [`DC_INDEX_W-1:0] index,
  output logic [`DC_TAG_W-1:0]   tag,
  output logic [`DC_WSEL_W-1:0]  word_sel,
  output dc_word_u               merged,
  output logic                   store_en,
  output logic [`DC_WORD_W-1:0]  rdata,
  array_ctrl_if.data             ctl
);

  logic                  cap_wr;
  logic [1:0]            cap_size;
  logic [1:0]            cap_lane;
  logic [`DC_ADDR_W-1:0] cap_addr;
  logic [`DC_WORD_W-1:0] cap_wdata;
  logic [1:0]            sel_size;
  logic [1:0]            sel_lane;
  logic [`DC_ADDR_W-1:0] sel_addr;
  logic [`DC_WORD_W-1:0] sel_wdata;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      cap_wr <= 1'b0;
    end else if (ctl.capture) begin
      cap_wr <= cpu_wr;
    end
  end

  always_ff @(posedge clk) begin
    if (ctl.capture) begin
      cap_size  <= cpu_size;
      cap_lane  <= cpu_lane;
      cap_addr  <= cpu_addr;
      cap_wdata <= cpu_wdata;
    end
  end

  // the parked miss is replayed through the same path as a live request
  // and a miss is only parked from a live request, so the replay is always valid
  assign req_valid = ctl.use_captured || cpu_req;
  assign req_wr    = ctl.use_captured ? cap_wr    : cpu_wr;
  assign sel_size  = ctl.use_captured ? cap_size  : cpu_size;
  assign sel_lane  = ctl.use_captured ? cap_lane  : cpu_lane;
  assign sel_addr  = ctl.use_captured ? cap_addr  : cpu_addr;
  assign sel_wdata = ctl.use_captured ? cap_wdata : cpu_wdata;

  assign {tag, index, word_sel} = sel_addr;

  // stores only land on a hit, which also keeps them out of the fill beats
  assign store_en = req_valid && req_wr && hit;

  always_comb begin
    merged = old_word;
    case (sel_size)
      `DC_SZ_FULL:   merged = sel_wdata;
      `DC_SZ_LANE32: merged.lane[sel_lane] = sel_wdata[31:0];
      `DC_SZ_HALF36: merged.half[sel_lane[1]] =
                       {{(64 - `DC_HALF36_W){1'b0}}, sel_wdata[`DC_HALF36_W-1:0]};
      default:       merged = sel_wdata;
    endcase
  end

  always_ff @(posedge clk) begin
    if (req_valid && !req_wr) begin
      rdata <= old_word;
    end
  end

endmodule

/* design/array_ctrl_if.sv */
`timescale 1ns/1ps

// control strobes from the miss FSM to the arrays, the request path
// and the beat counter
interface array_ctrl_if;

  logic use_captured;
  logic capture;
  logic tag_write;
  logic data_write_fill;
  logic rd_victim;
  logic beat_clear;
  logic beat_step;

  modport fsm (
    output use_captured, capture, tag_write, data_write_fill,
    output rd_victim, beat_clear, beat_step
  );

  modport tags (
    input tag_write
  );

  modport data (
    input use_captured, capture, data_write_fill, rd_victim
  );

  modport counter (
    input beat_clear, beat_step
  );

endinterface

/* design/beat_counter.sv */
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module beat_counter (
  input  logic                  clk,
  input  logic                  rst,
  output logic [`DC_WSEL_W-1:0] beat,
  output logic                  beat_last,
  array_ctrl_if.counter         ctl
);

  // word position inside the line for writeback and fill beats
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      beat <= '0;
    end else if (ctl.beat_clear) begin
      beat <= '0;
    end else if (ctl.beat_step) begin
      // wraps back to zero after the last word of the line
      beat <= beat + 1'b1;
    end
  end

  assign beat_last = (beat == '1);

endmodule

/* design/data_store.sv */
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module data_store
  import dcache_pkg::*;
(
  input  logic                   clk,
  input  logic [`DC_INDEX_W-1:0] index,
  input  logic [`DC_WSEL_W-1:0]  word_sel,
  input  logic [`DC_WSEL_W-1:0]  beat,
  input  logic [`DC_WORD_W-1:0]  fill_data,
  input  dc_word_u               wdata,
  input  logic                   we,
  output dc_word_u               rdata,
  array_ctrl_if.data             ctl
);

  localparam int words = 1 << (`DC_INDEX_W + `DC_WSEL_W);

  dc_word_u                                 mem [words];
  logic [`DC_WSEL_W-1:0]                    word_addr;
  logic [`DC_INDEX_W+`DC_WSEL_W-1:0]        addr;

  // line traffic walks the words by beat, core accesses use their own word select
  assign word_addr = (ctl.rd_victim || ctl.data_write_fill) ? beat : word_sel;
  assign addr      = {index, word_addr};

  always_ff @(posedge clk) begin
    if (ctl.data_write_fill) begin
      mem[addr] <= fill_data;
    end else if (we) begin
      mem[addr] <= wdata;
    end
  end

  assign rdata = mem[addr];

endmodule

/* design/dcache_cfg.svh */
`ifndef DCACHE_CFG_SVH
`define DCACHE_CFG_SVH

// core word address, split from the top down into tag, index and word select
`define DC_ADDR_W   16
`define DC_INDEX_W  4
`define DC_WSEL_W   2
`define DC_TAG_W    (`DC_ADDR_W - `DC_INDEX_W - `DC_WSEL_W)

// one cache word, four of them make a line
`define DC_WORD_W   128

// store size codes carried on cpu_size
`define DC_SZ_FULL   2'b00
`define DC_SZ_LANE32 2'b01
`define DC_SZ_HALF36 2'b10

// width of the narrow store that lands in a 64-bit half
`define DC_HALF36_W 36

`endif

/* design/dcache_fsm.sv */
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module dcache_fsm (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  hit,
  input  logic                  victim_dirty,
  input  logic                  req_valid,
  input  logic                  req_wr,
  input  logic                  mem_resp,
  input  logic [`DC_WSEL_W-1:0] beat,
  input  logic                  beat_last,
  output logic                  stall,
  output logic                  rvalid,
  output logic                  mem_req,
  output logic                  mem_we,
  array_ctrl_if.fsm             ctl
);

  typedef enum logic [2:0] {
    st_idle,
    st_writeback,
    st_fill_req,
    st_fill_wait,
    st_replay
  } state_t;

  state_t state;
  state_t next_state;
  logic   rd_done;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= st_idle;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state          = state;
    mem_req             = 1'b0;
    mem_we              = 1'b0;
    ctl.capture         = 1'b0;
    ctl.tag_write       = 1'b0;
    ctl.data_write_fill = 1'b0;
    ctl.rd_victim       = 1'b0;
    ctl.beat_clear      = 1'b0;
    ctl.beat_step       = 1'b0;

    case (state)
      st_idle: begin
        // hits finish here, a miss parks the request and starts the line swap
        if (req_valid && !hit) begin
          ctl.capture    = 1'b1;
          ctl.beat_clear = 1'b1;
          next_state     = victim_dirty ? st_writeback : st_fill_req;
        end
      end

      st_writeback: begin
        // one victim word leaves per cycle, no back-pressure from memory
        mem_req       = 1'b1;
        mem_we        = 1'b1;
        ctl.rd_victim = 1'b1;
        ctl.beat_step = 1'b1;
        if (beat_last) begin
          next_state = st_fill_req;
        end
      end

      st_fill_req: begin
        // the fill address carries the beat, so it must sit at word zero
        if (beat == '0) begin
          mem_req    = 1'b1;
          next_state = st_fill_wait;
        end else begin
          ctl.beat_clear = 1'b1;
        end
      end

      st_fill_wait: begin
        if (mem_resp) begin
          ctl.data_write_fill = 1'b1;
          ctl.beat_step       = 1'b1;
          if (beat_last) begin
            ctl.tag_write = 1'b1;
            next_state    = st_replay;
          end
        end
      end

      st_replay: begin
        // the captured access now hits and completes in this cycle
        next_state = st_idle;
      end

      default: begin
        next_state = st_idle;
      end
    endcase
  end

  // outside idle the arrays are steered by the parked request
  assign ctl.use_captured = (state != st_idle);
  assign stall            = (state != st_idle);

  // read data is returned one cycle after a hit in idle or after the replay
  assign rd_done = !req_wr &&
                   (((state == st_idle) && req_valid && hit) || (state == st_replay));

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rvalid <= 1'b0;
    end else begin
      rvalid <= rd_done;
    end
  end

endmodule

/* design/dcache_pkg.sv */
`include "dcache_cfg.svh"

package dcache_pkg;

  // one cache word, read as four 32-bit lanes for lane stores
  // or as two 64-bit halves for the 36-bit store
  typedef union packed {
    logic [`DC_WORD_W/32-1:0][31:0] lane;
    logic [`DC_WORD_W/64-1:0][63:0] half;
  } dc_word_u;

endpackage

/* design/dcache_top.sv */
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module dcache_top
  import dcache_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  cpu_req,
  input  logic                  cpu_wr,
  input  logic [1:0]            cpu_size,
  input  logic [1:0]            cpu_lane,
  input  logic [`DC_ADDR_W-1:0] cpu_addr,
  input  logic [`DC_WORD_W-1:0] cpu_wdata,
  output logic                  stall,
  output logic                  rvalid,
  output logic [`DC_WORD_W-1:0] rdata,
  output logic                  mem_req,
  output logic                  mem_we,
  output logic [`DC_ADDR_W-1:0] mem_addr,
  output logic [`DC_WORD_W-1:0] mem_wdata,
  input  logic                  mem_resp,
  input  logic [`DC_WORD_W-1:0] mem_rdata
);

  logic                   hit;
  logic                   victim_dirty;
  logic [`DC_TAG_W-1:0]   victim_tag;
  logic                   req_valid;
  logic                   req_wr;
  logic [`DC_INDEX_W-1:0] index;
  logic [`DC_TAG_W-1:0]   tag;
  logic [`DC_WSEL_W-1:0]  word_sel;
  logic [`DC_WSEL_W-1:0]  beat;
  logic                   beat_last;
  logic                   store_en;
  dc_word_u               merged;
  dc_word_u               old_word;

  array_ctrl_if ctl ();

  dcache_fsm u_fsm (
    .clk(clk), .rst(rst), .hit(hit), .victim_dirty(victim_dirty),
    .req_valid(req_valid), .req_wr(req_wr), .mem_resp(mem_resp),
    .beat(beat), .beat_last(beat_last), .stall(stall), .rvalid(rvalid),
    .mem_req(mem_req), .mem_we(mem_we), .ctl(ctl)
  );

  beat_counter u_beat (
    .clk(clk), .rst(rst), .beat(beat), .beat_last(beat_last), .ctl(ctl)
  );

  tag_store u_tags (
    .clk(clk), .rst(rst), .index(index), .tag(tag), .set_dirty(store_en),
    .hit(hit), .victim_dirty(victim_dirty), .victim_tag(victim_tag), .ctl(ctl)
  );

  data_store u_data (
    .clk(clk), .index(index), .word_sel(word_sel), .beat(beat),
    .fill_data(mem_rdata), .wdata(merged), .we(store_en), .rdata(old_word), .ctl(ctl)
  );

  access_path u_access (
    .clk(clk), .rst(rst), .cpu_req(cpu_req), .cpu_wr(cpu_wr), .cpu_size(cpu_size),
    .cpu_lane(cpu_lane), .cpu_addr(cpu_addr), .cpu_wdata(cpu_wdata),
    .old_word(old_word), .hit(hit), .req_valid(req_valid), .req_wr(req_wr),
    .index(index), .tag(tag), .word_sel(word_sel), .merged(merged),
    .store_en(store_en), .rdata(rdata), .ctl(ctl)
  );

  // writeback beats go to the victim line, the fill goes to the requested line
  assign mem_addr  = {(mem_we ? victim_tag : tag), index, beat};
  assign mem_wdata = old_word;

endmodule

/* design/tag_store.sv */
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module tag_store (
  input  logic                   clk,
  input  logic                   rst,
  input  logic [`DC_INDEX_W-1:0] index,
  input  logic [`DC_TAG_W-1:0]   tag,
  input  logic                   set_dirty,
  output logic                   hit,
  output logic                   victim_dirty,
  output logic [`DC_TAG_W-1:0]   victim_tag,
  array_ctrl_if.tags             ctl
);

  localparam int sets = 1 << `DC_INDEX_W;

  logic [sets-1:0]                valid;
  logic [sets-1:0]                dirty;
  logic [sets-1:0][`DC_TAG_W-1:0] tags;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      valid <= '0;
      dirty <= '0;
      tags  <= '0;
    end else if (ctl.tag_write) begin
      // a completed fill leaves the new line valid and clean
      valid[index] <= 1'b1;
      dirty[index] <= 1'b0;
      tags[index]  <= tag;
    end else if (set_dirty) begin
      dirty[index] <= 1'b1;
    end
  end

  assign victim_tag = tags[index];
  assign hit        = valid[index] && (tags[index] == tag);

  // only a valid line that was written needs to go back to memory
  assign victim_dirty = valid[index] && dirty[index];

endmodule

/* dv/mem_responder.sv */
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module mem_responder (
  input  logic                  clk,
  input  logic                  mem_req,
  input  logic                  mem_we,
  input  logic [`DC_ADDR_W-1:0] mem_addr,
  input  logic [`DC_WORD_W-1:0] mem_wdata,
  output logic                  mem_resp,
  output logic [`DC_WORD_W-1:0] mem_rdata
);

  logic [`DC_WORD_W-1:0] mem [0:(1<<`DC_ADDR_W)-1];
  logic [`DC_ADDR_W-1:0] line_addr;

  // each word starts from a value that depends on its whole address
  function automatic logic [`DC_WORD_W-1:0] pattern_word(input logic [`DC_ADDR_W-1:0] a);
    return {a, ~a, a ^ 16'h5a5a, a + 16'h1111, a ^ 16'hc3c3, a - 16'h2222,
            {a[7:0], a[15:8]}, a ^ 16'h0ff0};
  endfunction

  initial begin
    mem_resp  = 1'b0;
    mem_rdata = '0;
    for (int a = 0; a < (1 << `DC_ADDR_W); a++) begin
      mem[a] = pattern_word(a[`DC_ADDR_W-1:0]);
    end
  end

  // requests are sampled and responses driven on the falling edge
  always begin
    @(negedge clk);
    mem_resp = 1'b0;
    if (mem_req && mem_we) begin
      mem[mem_addr] = mem_wdata;
    end else if (mem_req) begin
      line_addr = mem_addr;
      for (int b = 0; b < 4; b++) begin
        // one to four cycles before each beat, so beats may also come back to back
        repeat ($urandom_range(1, 4)) @(negedge clk) mem_resp = 1'b0;
        mem_resp  = 1'b1;
        mem_rdata = mem[{line_addr[`DC_ADDR_W-1:`DC_WSEL_W], b[`DC_WSEL_W-1:0]}];
      end
    end
  end

endmodule

/* dv/tb_dcache.sv */
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module tb_dcache;

  localparam int num_dir_ops  = 16;
  localparam int num_rand_ops = 500;
  localparam int cycle_limit  = 200 * (num_dir_ops + num_rand_ops);

  logic                  clk;
  logic                  rst;
  logic                  cpu_req;
  logic                  cpu_wr;
  logic [1:0]            cpu_size;
  logic [1:0]            cpu_lane;
  logic [`DC_ADDR_W-1:0] cpu_addr;
  logic [`DC_WORD_W-1:0] cpu_wdata;
  logic                  stall;
  logic                  rvalid;
  logic [`DC_WORD_W-1:0] rdata;
  logic                  mem_req;
  logic                  mem_we;
  logic [`DC_ADDR_W-1:0] mem_addr;
  logic [`DC_WORD_W-1:0] mem_wdata;
  logic                  mem_resp;
  logic [`DC_WORD_W-1:0] mem_rdata;

  // architectural memory contents, updated as each store is issued
  logic [`DC_WORD_W-1:0] model [0:(1<<`DC_ADDR_W)-1];

  int          cycles    = 0;
  int          checks    = 0;
  int          errors    = 0;
  int          err_mark  = 0;
  int          wb_beats  = 0;
  int          fill_reqs = 0;
  int          wb_mark;
  int          fill_mark;
  int unsigned rnd;
  logic        missed;

  dcache_top DUT (.*);

  mem_responder u_mem (.*);

  initial clk = 1'b0;
  always #4 clk = ~clk;

  function automatic logic [`DC_WORD_W-1:0] pattern_word(input logic [`DC_ADDR_W-1:0] a);
    return {a, ~a, a ^ 16'h5a5a, a + 16'h1111, a ^ 16'hc3c3, a - 16'h2222,
            {a[7:0], a[15:8]}, a ^ 16'h0ff0};
  endfunction

  // full store, one 32-bit lane, or 36 bits zero-extended into one 64-bit half
  function automatic logic [`DC_WORD_W-1:0] apply_store(input logic [`DC_WORD_W-1:0] old,
      input logic [1:0] size, lane, input logic [`DC_WORD_W-1:0] data);
    logic [`DC_WORD_W-1:0] r;
    r = old;
    if (size == `DC_SZ_FULL) r = data;
    else if (size == `DC_SZ_LANE32) r[lane*32 +: 32] = data[31:0];
    else r[lane[1]*64 +: 64] = {{(64 - `DC_HALF36_W){1'b0}}, data[`DC_HALF36_W-1:0]};
    return r;
  endfunction

  task automatic note_error(input string msg);
    errors++;
    $display("ERROR at %0t: %s", $time, msg);
  endtask

  task automatic report_mismatch(input string name, input logic [`DC_WORD_W-1:0] got, exp);
    errors++;
    $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
  endtask

  task automatic end_test(input int num, input string name);
    $display("test %0d %s: %0d errors", num, name, errors - err_mark);
    err_mark = errors;
  endtask

  task automatic do_access(input logic wr, input logic [1:0] size, lane,
      input logic [`DC_ADDR_W-1:0] addr, input logic [`DC_WORD_W-1:0] wdata, output logic miss);
    logic [`DC_WORD_W-1:0] expect_word;
    @(negedge clk);
    while (stall) @(negedge clk);
    if (wr) model[addr] = apply_store(model[addr], size, lane, wdata);
    expect_word = model[addr];
    cpu_req   = 1'b1;
    cpu_wr    = wr;
    cpu_size  = size;
    cpu_lane  = lane;
    cpu_addr  = addr;
    cpu_wdata = wdata;
    @(negedge clk);
    cpu_req = 1'b0;
    miss    = stall;
    // read data of a miss arrives in the cycle where stall drops
    while (stall) @(negedge clk);
    checks++;
    if (!wr && !rvalid) note_error($sformatf("no rvalid for read of %h", addr));
    else if (!wr && rdata !== expect_word) report_mismatch("rdata", rdata, expect_word);
    else if (wr && rvalid) note_error($sformatf("rvalid raised for write to %h", addr));
  endtask

  task automatic store_and_check(input logic [1:0] size, lane, input logic [`DC_ADDR_W-1:0] addr);
    logic miss;
    do_access(1'b1, size, lane, addr, {$urandom, $urandom, $urandom, $urandom}, miss);
    do_access(1'b0, `DC_SZ_FULL, 2'd0, addr, '0, miss);
  endtask

  // every writeback beat must carry the current contents of the victim word
  always @(negedge clk) begin
    if (!rst && mem_req && mem_we) begin
      wb_beats++;
      checks++;
      if (mem_wdata !== model[mem_addr]) report_mismatch("mem_wdata", mem_wdata, model[mem_addr]);
    end else if (!rst && mem_req) begin
      fill_reqs++;
      checks++;
      if (mem_addr[`DC_WSEL_W-1:0] != '0) note_error($sformatf("fill at %h not at word 0", mem_addr));
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= cycle_limit) begin
      $display("ERROR: run stopped by timeout after %0d cycles", cycles);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  initial begin
    rnd       = $urandom(32'h8177d427);
    rst       = 1'b1;
    cpu_req   = 1'b0;
    cpu_wr    = 1'b0;
    cpu_size  = `DC_SZ_FULL;
    cpu_lane  = 2'd0;
    cpu_addr  = '0;
    cpu_wdata = '0;
    for (int a = 0; a < (1 << `DC_ADDR_W); a++) begin
      model[a] = pattern_word(a[`DC_ADDR_W-1:0]);
    end
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    @(negedge clk);
    checks++;
    if (stall || rvalid || mem_req) note_error("stall, rvalid or mem_req high after reset");
    fill_mark = fill_reqs;
    do_access(1'b0, `DC_SZ_FULL, 2'd0, 16'h0044, '0, missed);
    if (!missed || fill_reqs != fill_mark + 1) note_error("cold read of 0044 did not miss");
    do_access(1'b0, `DC_SZ_FULL, 2'd0, 16'h1238, '0, missed);
    if (!missed) note_error("cold read of 1238 did not miss");
    end_test(1, "reset and cold read miss");

    fill_mark = fill_reqs;
    do_access(1'b0, `DC_SZ_FULL, 2'd0, 16'h0047, '0, missed);
    if (missed || fill_reqs != fill_mark) note_error("second read of a loaded line missed");
    end_test(2, "read hit");

    store_and_check(`DC_SZ_FULL, 2'd0, 16'h0045);
    store_and_check(`DC_SZ_LANE32, 2'd2, 16'h0046);
    store_and_check(`DC_SZ_HALF36, 2'd2, 16'h0047);
    store_and_check(`DC_SZ_HALF36, 2'd1, 16'h0208);
    store_and_check(`DC_SZ_LANE32, 2'd3, 16'h3a0d);
    end_test(3, "store sizes");

    do_access(1'b1, `DC_SZ_FULL, 2'd0, 16'h0124, {$urandom, $urandom, $urandom, $urandom}, missed);
    wb_mark   = wb_beats;
    fill_mark = fill_reqs;
    do_access(1'b0, `DC_SZ_FULL, 2'd0, 16'h0164, '0, missed);
    if (wb_beats != wb_mark + 4 || fill_reqs != fill_mark + 1)
      note_error("conflicting read did not write back four beats and fill once");
    do_access(1'b0, `DC_SZ_FULL, 2'd0, 16'h0124, '0, missed);
    end_test(4, "dirty eviction");

    // 256 words over 16 sets keep four tags fighting for each set
    for (int i = 0; i < num_rand_ops; i++) begin
      do_access($urandom_range(0, 1), $urandom_range(0, 2), $urandom_range(0, 3),
                $urandom_range(0, 255), {$urandom, $urandom, $urandom, $urandom}, missed);
    end
    end_test(5, "random operations");

    $display("summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* tb.f */
+incdir+design
design/dcache_pkg.sv
design/array_ctrl_if.sv
design/dcache_fsm.sv
design/beat_counter.sv
design/tag_store.sv
design/data_store.sv
design/access_path.sv
design/dcache_top.sv
dv/mem_responder.sv
dv/tb_dcache.sv
